// ==== verilog/hci_pkg.sv ====
// Widths, queue depths and register map of the PIO front end
// Threshold fields are 4 bits wide and sit at bits 3:0 and 11:8 of their registers
`default_nettype none

package hci_pkg;

  localparam int unsigned DataWidth   = 32;
  localparam int unsigned CmdDwords   = 2;
  localparam int unsigned CmdWidth    = DataWidth * CmdDwords;
  localparam int unsigned CmdCntWidth = $clog2(CmdDwords);

  // Queue depths in entries
  localparam int unsigned CmdDepth  = 8;
  localparam int unsigned TxDepth   = 16;
  localparam int unsigned RxDepth   = 16;
  localparam int unsigned RespDepth = 8;

  localparam int unsigned ThldWidth = 4;
  localparam int unsigned AddrWidth = 3;

  // Register offsets
  localparam logic [AddrWidth-1:0] RegResetCtrl   = 3'd0;
  localparam logic [AddrWidth-1:0] RegQueueThld   = 3'd1; // cmd 3:0, resp 11:8
  localparam logic [AddrWidth-1:0] RegDataThld    = 3'd2; // rx 3:0, tx 11:8
  localparam logic [AddrWidth-1:0] RegCmdPort     = 3'd3;
  localparam logic [AddrWidth-1:0] RegXferPort    = 3'd4;
  localparam logic [AddrWidth-1:0] RegRespPort    = 3'd5;
  localparam logic [AddrWidth-1:0] RegQueueStatus = 3'd6;

  typedef struct packed {
    logic                 wr;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic                 ack;
    logic                 err;
    logic [DataWidth-1:0] rdata;
  } reg_rsp_t;

  // Cast to a vector this gives cmd in bit 0, resp in bit 3
  typedef struct packed {
    logic resp;
    logic tx;
    logic rx;
    logic cmd;
  } queue_flags_t;

  typedef struct packed {
    logic [ThldWidth-1:0] cmd;
    logic [ThldWidth-1:0] rx;
    logic [ThldWidth-1:0] tx;
    logic [ThldWidth-1:0] resp;
  } thld_t;

endpackage

`default_nettype wire

// ==== verilog/hci_sync_fifo.sv ====
// Circular buffer with an occupancy counter, so full and empty are exact
// Flush drops all entries in one cycle
`timescale 1ns/1ps
`default_nettype none

module hci_sync_fifo #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             flush_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o,
  output logic             empty_o
);

  logic [Width-1:0]           mem_q [Depth];
  logic [$clog2(Depth)-1:0]   wptr_q;
  logic [$clog2(Depth)-1:0]   rptr_q;
  logic [$clog2(Depth+1)-1:0] count_q;
  logic                       push;
  logic                       pop;

  assign wready_o = count_q != Depth;
  assign rvalid_o = count_q != '0;
  assign empty_o  = count_q == '0;
  assign rdata_o  = mem_q[rptr_q];
  assign push     = wvalid_i && wready_o;
  assign pop      = rvalid_o && rready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == Depth - 1) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == Depth - 1) ? '0 : rptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // Idle or simultaneous push and pop
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hci_read_buffer.sv ====
// One-entry buffer between a queue and a readable port
`timescale 1ns/1ps
`default_nettype none

module hci_read_buffer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic                          fifo_valid_i,
  output logic                          fifo_ready_o,
  input  logic [hci_pkg::DataWidth-1:0] fifo_data_i,
  output logic                          valid_o,
  output logic [hci_pkg::DataWidth-1:0] data_o,
  input  logic                          pop_i
);
  import hci_pkg::*;

  logic                 valid_q;
  logic [DataWidth-1:0] data_q;

  assign fifo_ready_o = !valid_q; // Fill only when empty
  assign valid_o      = valid_q;
  assign data_o       = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (flush_i || pop_i) begin
      valid_q <= 1'b0;
    end else if (fifo_valid_i) begin
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_valid_i && fifo_ready_o) begin
      data_q <= fifo_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hci_queue_ctrl.sv ====
// Clears queue reset bits once the queue is empty and clamps thresholds to the depths
// RX and TX thresholds are log2 encoded, command and response ones are entry counts
`timescale 1ns/1ps
`default_nettype none

module hci_queue_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  hci_pkg::queue_flags_t qrst_i,
  input  hci_pkg::queue_flags_t empty_i,
  output hci_pkg::queue_flags_t qrst_clr_o,
  input  hci_pkg::thld_t        thld_i,
  output hci_pkg::thld_t        thld_o
);
  import hci_pkg::*;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      qrst_clr_o <= '0;
      thld_o     <= '0;
    end else begin
      qrst_clr_o <= qrst_i & empty_i;

      thld_o.cmd <= (thld_i.cmd > CmdDepth) ? ThldWidth'(CmdDepth) : thld_i.cmd;

      // 2^(rx+1) must stay below the RX depth
      if ((32'd1 << (thld_i.rx + 1)) >= RxDepth) begin
        thld_o.rx <= ThldWidth'($clog2(RxDepth) - 2);
      end else begin
        thld_o.rx <= thld_i.rx;
      end

      // 2^(tx+1) may reach the TX depth
      if ((32'd1 << (thld_i.tx + 1)) > TxDepth) begin
        thld_o.tx <= ThldWidth'($clog2(TxDepth) - 1);
      end else begin
        thld_o.tx <= thld_i.tx;
      end

      thld_o.resp <= (thld_i.resp >= RespDepth) ? ThldWidth'(RespDepth - 1) : thld_i.resp;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hci_cmd_assembler.sv ====
// Collects CmdDwords data words into one command, word 0 in the low bits
// Holds off new words while a complete command waits for the queue
`timescale 1ns/1ps
`default_nettype none

module hci_cmd_assembler (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         flush_i,
  input  logic                         word_valid_i,
  output logic                         word_ready_o,
  input  logic [hci_pkg::DataWidth-1:0] word_i,
  output logic                         cmd_valid_o,
  input  logic                         cmd_ready_i,
  output logic [hci_pkg::CmdWidth-1:0] cmd_o
);
  import hci_pkg::*;

  logic [CmdCntWidth-1:0] cnt_q;   // Next word position
  logic                   valid_q;
  logic [CmdWidth-1:0]    cmd_q;
  logic                   word_take;
  logic                   last_word;

  assign word_ready_o = !valid_q;
  assign word_take    = word_valid_i && word_ready_o;
  assign last_word    = cnt_q == CmdCntWidth'(CmdDwords - 1);
  assign cmd_valid_o  = valid_q;
  assign cmd_o        = cmd_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else if (flush_i) begin
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else if (word_take) begin
      cnt_q   <= last_word ? '0 : cnt_q + 1'b1;
      valid_q <= last_word; // Offered in the cycle after the last word
    end else if (valid_q && cmd_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_take) begin
      cmd_q[cnt_q*DataWidth +: DataWidth] <= word_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hci_reg_decode.sv ====
// Four-phase register port with one access in flight at a time
// Port accesses stall until the queue handshake completes; offset 7 answers with err
`timescale 1ns/1ps
`default_nettype none

module hci_reg_decode (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          reg_req_i,
  input  hci_pkg::reg_req_t             reg_i,
  output hci_pkg::reg_rsp_t             reg_o,
  output hci_pkg::queue_flags_t         qrst_o,
  input  hci_pkg::queue_flags_t         qrst_clr_i,
  input  hci_pkg::queue_flags_t         empty_i,
  output hci_pkg::thld_t                thld_o,
  output logic                          cmd_wvalid_o,
  input  logic                          cmd_wready_i,
  output logic [hci_pkg::DataWidth-1:0] cmd_wdata_o,
  output logic                          tx_wvalid_o,
  input  logic                          tx_wready_i,
  output logic [hci_pkg::DataWidth-1:0] tx_wdata_o,
  input  logic                          rx_valid_i,
  input  logic [hci_pkg::DataWidth-1:0] rx_data_i,
  output logic                          rx_pop_o,
  input  logic                          resp_valid_i,
  input  logic [hci_pkg::DataWidth-1:0] resp_data_i,
  output logic                          resp_pop_o
);
  import hci_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    Wait,
    Ack,
    Release
  } state_e;

  state_e               state_q;
  logic                 active;   // Request seen, not yet answered
  logic                 reg_wr;   // First cycle of a write
  logic                 done;     // Target has completed the access
  logic                 err_d;
  logic                 err_q;
  logic [DataWidth-1:0] rdata_d;
  logic [DataWidth-1:0] rdata_q;
  queue_flags_t         qrst_q;
  queue_flags_t         qrst_set;
  thld_t                thld_q;

  assign active = reg_req_i && (state_q == Idle || state_q == Wait);
  assign reg_wr = reg_req_i && state_q == Idle && reg_i.wr;

  // Queue routing, writes to a queue under reset are dropped
  assign cmd_wvalid_o = active && reg_i.wr && reg_i.addr == RegCmdPort && !qrst_q.cmd;
  assign cmd_wdata_o  = reg_i.wdata;
  assign tx_wvalid_o  = active && reg_i.wr && reg_i.addr == RegXferPort && !qrst_q.tx;
  assign tx_wdata_o   = reg_i.wdata;
  assign rx_pop_o     = active && !reg_i.wr && reg_i.addr == RegXferPort && rx_valid_i;
  assign resp_pop_o   = active && !reg_i.wr && reg_i.addr == RegRespPort && resp_valid_i;

  assign qrst_set = (reg_wr && reg_i.addr == RegResetCtrl) ?
                    queue_flags_t'(reg_i.wdata[3:0]) : '0;

  // Threshold readback assumes 4-bit fields
  always_comb begin
    done    = 1'b1;
    err_d   = 1'b0;
    rdata_d = '0;
    case (reg_i.addr)
      RegResetCtrl:   rdata_d = DataWidth'(qrst_q);
      RegQueueThld:   rdata_d = DataWidth'({thld_q.resp, 4'b0, thld_q.cmd});
      RegDataThld:    rdata_d = DataWidth'({thld_q.tx, 4'b0, thld_q.rx});
      RegCmdPort:     done = !reg_i.wr || qrst_q.cmd || cmd_wready_i;
      RegXferPort: begin
        rdata_d = rx_data_i;
        done    = reg_i.wr ? (qrst_q.tx || tx_wready_i) : rx_valid_i;
      end
      RegRespPort: begin
        rdata_d = resp_data_i;
        done    = reg_i.wr || resp_valid_i; // Writes here are ignored
      end
      RegQueueStatus: rdata_d = DataWidth'(empty_i);
      default:        err_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        Idle, Wait: begin
          if (reg_req_i) begin
            state_q <= done ? Ack : Wait;
          end
        end
        Ack: begin
          if (!reg_req_i) begin
            state_q <= Release; // Ack drops here
          end
        end
        default: state_q <= Idle;
      endcase
      if (active && done) begin
        err_q <= err_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (active && done) begin
      rdata_q <= rdata_d;
    end
  end

  // Reset bits are set by software and cleared once the queue is empty
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      qrst_q <= '0;
      thld_q <= '0;
    end else begin
      qrst_q <= (qrst_q & ~qrst_clr_i) | qrst_set;
      if (reg_wr && reg_i.addr == RegQueueThld) begin
        thld_q.cmd  <= reg_i.wdata[ThldWidth-1:0];
        thld_q.resp <= reg_i.wdata[8 +: ThldWidth];
      end
      if (reg_wr && reg_i.addr == RegDataThld) begin
        thld_q.rx <= reg_i.wdata[ThldWidth-1:0];
        thld_q.tx <= reg_i.wdata[8 +: ThldWidth];
      end
    end
  end

  assign reg_o  = '{ack: (state_q == Ack), err: err_q, rdata: rdata_q};
  assign qrst_o = qrst_q;
  assign thld_o = thld_q;

endmodule

`default_nettype wire

// ==== verilog/hci_pio_top.sv ====
// PIO front end, bus engine side of all four queues is exposed as valid/ready
// A queue reset bit flushes the FIFO and the block attached to it
`timescale 1ns/1ps
`default_nettype none

module hci_pio_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          reg_req_i,
  input  hci_pkg::reg_req_t             reg_i,
  output hci_pkg::reg_rsp_t             reg_o,
  output hci_pkg::thld_t                thld_o,
  output logic                          cmd_rvalid_o,
  input  logic                          cmd_rready_i,
  output logic [hci_pkg::CmdWidth-1:0]  cmd_rdata_o,
  output logic                          tx_rvalid_o,
  input  logic                          tx_rready_i,
  output logic [hci_pkg::DataWidth-1:0] tx_rdata_o,
  input  logic                          rx_wvalid_i,
  output logic                          rx_wready_o,
  input  logic [hci_pkg::DataWidth-1:0] rx_wdata_i,
  input  logic                          resp_wvalid_i,
  output logic                          resp_wready_o,
  input  logic [hci_pkg::DataWidth-1:0] resp_wdata_i
);
  import hci_pkg::*;

  queue_flags_t         qrst;
  queue_flags_t         qrst_clr;
  queue_flags_t         empty;     // One flag per FIFO
  thld_t                thld_raw;  // As written by software

  logic                 cmd_wvalid;
  logic                 cmd_wready;
  logic [DataWidth-1:0] cmd_wdata;
  logic                 asm_valid;
  logic                 asm_ready;
  logic [CmdWidth-1:0]  asm_cmd;

  logic                 tx_wvalid;
  logic                 tx_wready;
  logic [DataWidth-1:0] tx_wdata;

  logic                 rx_fvalid;
  logic                 rx_fready;
  logic [DataWidth-1:0] rx_fdata;
  logic                 rx_valid;
  logic [DataWidth-1:0] rx_data;
  logic                 rx_pop;

  logic                 resp_fvalid;
  logic                 resp_fready;
  logic [DataWidth-1:0] resp_fdata;
  logic                 resp_valid;
  logic [DataWidth-1:0] resp_data;
  logic                 resp_pop;

  hci_reg_decode u_decode (
    .clk_i,
    .rst_ni,
    .reg_req_i,
    .reg_i,
    .reg_o,
    .qrst_o       (qrst),
    .qrst_clr_i   (qrst_clr),
    .empty_i      (empty),
    .thld_o       (thld_raw),
    .cmd_wvalid_o (cmd_wvalid),
    .cmd_wready_i (cmd_wready),
    .cmd_wdata_o  (cmd_wdata),
    .tx_wvalid_o  (tx_wvalid),
    .tx_wready_i  (tx_wready),
    .tx_wdata_o   (tx_wdata),
    .rx_valid_i   (rx_valid),
    .rx_data_i    (rx_data),
    .rx_pop_o     (rx_pop),
    .resp_valid_i (resp_valid),
    .resp_data_i  (resp_data),
    .resp_pop_o   (resp_pop)
  );

  hci_cmd_assembler u_cmd_asm (
    .clk_i,
    .rst_ni,
    .flush_i      (qrst.cmd),
    .word_valid_i (cmd_wvalid),
    .word_ready_o (cmd_wready),
    .word_i       (cmd_wdata),
    .cmd_valid_o  (asm_valid),
    .cmd_ready_i  (asm_ready),
    .cmd_o        (asm_cmd)
  );

  hci_queue_ctrl u_queue_ctrl (
    .clk_i,
    .rst_ni,
    .qrst_i     (qrst),
    .empty_i    (empty),
    .qrst_clr_o (qrst_clr),
    .thld_i     (thld_raw),
    .thld_o
  );

  hci_read_buffer u_rx_buf (
    .clk_i,
    .rst_ni,
    .flush_i      (qrst.rx),
    .fifo_valid_i (rx_fvalid),
    .fifo_ready_o (rx_fready),
    .fifo_data_i  (rx_fdata),
    .valid_o      (rx_valid),
    .data_o       (rx_data),
    .pop_i        (rx_pop)
  );

  hci_read_buffer u_resp_buf (
    .clk_i,
    .rst_ni,
    .flush_i      (qrst.resp),
    .fifo_valid_i (resp_fvalid),
    .fifo_ready_o (resp_fready),
    .fifo_data_i  (resp_fdata),
    .valid_o      (resp_valid),
    .data_o       (resp_data),
    .pop_i        (resp_pop)
  );

  hci_sync_fifo #(.Width(CmdWidth), .Depth(CmdDepth)) u_cmd_fifo (
    .clk_i,
    .rst_ni,
    .flush_i  (qrst.cmd),
    .wvalid_i (asm_valid),
    .wready_o (asm_ready),
    .wdata_i  (asm_cmd),
    .rvalid_o (cmd_rvalid_o),
    .rready_i (cmd_rready_i),
    .rdata_o  (cmd_rdata_o),
    .empty_o  (empty.cmd)
  );

  hci_sync_fifo #(.Width(DataWidth), .Depth(TxDepth)) u_tx_fifo (
    .clk_i,
    .rst_ni,
    .flush_i  (qrst.tx),
    .wvalid_i (tx_wvalid),
    .wready_o (tx_wready),
    .wdata_i  (tx_wdata),
    .rvalid_o (tx_rvalid_o),
    .rready_i (tx_rready_i),
    .rdata_o  (tx_rdata_o),
    .empty_o  (empty.tx)
  );

  hci_sync_fifo #(.Width(DataWidth), .Depth(RxDepth)) u_rx_fifo (
    .clk_i,
    .rst_ni,
    .flush_i  (qrst.rx),
    .wvalid_i (rx_wvalid_i),
    .wready_o (rx_wready_o),
    .wdata_i  (rx_wdata_i),
    .rvalid_o (rx_fvalid),
    .rready_i (rx_fready),
    .rdata_o  (rx_fdata),
    .empty_o  (empty.rx)
  );

  hci_sync_fifo #(.Width(DataWidth), .Depth(RespDepth)) u_resp_fifo (
    .clk_i,
    .rst_ni,
    .flush_i  (qrst.resp),
    .wvalid_i (resp_wvalid_i),
    .wready_o (resp_wready_o),
    .wdata_i  (resp_wdata_i),
    .rvalid_o (resp_fvalid),
    .rready_i (resp_fready),
    .rdata_o  (resp_fdata),
    .empty_o  (empty.resp)
  );

endmodule

`default_nettype wire

// ==== dv/hci_tb.sv ====
// Directed testbench that plays software on the register port and the bus engine on the queues
// Stops at the first mismatch and ends with a timeout after TimeoutCycles cycles
`timescale 1ns/1ps
`default_nettype none

module hci_tb;
  import hci_pkg::*;

  localparam int unsigned Seed          = 32'h8fb7;
  localparam int unsigned TimeoutCycles = 4000; // Tests need well under 1000 cycles

  logic                 clk_i;
  logic                 rst_ni;
  logic                 reg_req_i;
  reg_req_t             reg_i;
  reg_rsp_t             reg_o;
  thld_t                thld_o;
  logic                 cmd_rvalid_o;
  logic                 cmd_rready_i;
  logic [CmdWidth-1:0]  cmd_rdata_o;
  logic                 tx_rvalid_o;
  logic                 tx_rready_i;
  logic [DataWidth-1:0] tx_rdata_o;
  logic                 rx_wvalid_i;
  logic                 rx_wready_o;
  logic [DataWidth-1:0] rx_wdata_i;
  logic                 resp_wvalid_i;
  logic                 resp_wready_o;
  logic [DataWidth-1:0] resp_wdata_i;

  int unsigned          cycles = 0;
  logic [CmdWidth-1:0]  cmd_exp [$];  // Commands in the order software wrote them
  logic [DataWidth-1:0] word_exp [$]; // TX words in write order

  hci_pio_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == TimeoutCycles) begin
      stop_run($sformatf("Timeout, run not finished after %0d cycles", TimeoutCycles));
    end
  end

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_rsp(input string name, input reg_rsp_t exp, input reg_rsp_t act);
    if (act !== exp) begin
      stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_cmd(input string name, input logic [CmdWidth-1:0] exp,
                           input logic [CmdWidth-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_word(input string name, input logic [DataWidth-1:0] exp,
                            input logic [DataWidth-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_thld(input string name, input thld_t exp, input thld_t act);
    if (act !== exp) begin
      stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  function automatic reg_rsp_t acked(input logic [DataWidth-1:0] data);
    reg_rsp_t rsp;
    rsp.ack   = 1'b1;
    rsp.err   = 1'b0;
    rsp.rdata = data;
    return rsp;
  endfunction

  // Clamp rules for the exported thresholds
  function automatic thld_t clamp_thld(input thld_t raw);
    thld_t res;
    res = raw;
    if (raw.cmd > CmdDepth) begin
      res.cmd = ThldWidth'(CmdDepth);
    end
    if ((1 << (int'(raw.rx) + 1)) >= RxDepth) begin
      res.rx = ThldWidth'($clog2(RxDepth) - 2);
    end
    if ((1 << (int'(raw.tx) + 1)) > TxDepth) begin
      res.tx = ThldWidth'($clog2(TxDepth) - 1);
    end
    if (raw.resp > RespDepth - 1) begin
      res.resp = ThldWidth'(RespDepth - 1);
    end
    return res;
  endfunction

  task automatic reg_start(input logic wr, input logic [AddrWidth-1:0] addr,
                           input logic [DataWidth-1:0] wdata);
    reg_i     = '{wr: wr, addr: addr, wdata: wdata};
    reg_req_i = 1'b1;
  endtask

  // Waits for ack, then drops the request and waits until ack falls
  task automatic reg_finish(output reg_rsp_t rsp);
    do begin
      next_cycle();
    end while (!reg_o.ack);
    rsp       = reg_o;
    reg_req_i = 1'b0;
    do begin
      next_cycle();
    end while (reg_o.ack);
  endtask

  task automatic reg_write(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
    reg_rsp_t rsp;
    reg_start(1'b1, addr, data);
    reg_finish(rsp);
    if (rsp.err) begin
      stop_run($sformatf("Write to offset %0d was answered with an error", addr));
    end
  endtask

  task automatic reg_read(input logic [AddrWidth-1:0] addr, output reg_rsp_t rsp);
    reg_start(1'b0, addr, '0);
    reg_finish(rsp);
  endtask

  task automatic pop_cmd(input string name);
    logic [CmdWidth-1:0] exp;
    while (!cmd_rvalid_o) begin
      next_cycle();
    end
    exp = cmd_exp.pop_front();
    check_cmd(name, exp, cmd_rdata_o);
    cmd_rready_i = 1'b1;
    next_cycle();
    cmd_rready_i = 1'b0;
  endtask

  task automatic pop_tx(input string name);
    logic [DataWidth-1:0] exp;
    while (!tx_rvalid_o) begin
      next_cycle();
    end
    exp = word_exp.pop_front();
    check_word(name, exp, tx_rdata_o);
    tx_rready_i = 1'b1;
    next_cycle();
    tx_rready_i = 1'b0;
  endtask

  // Bus engine side push into the RX or the response queue
  task automatic push_word(input logic to_resp, input logic [DataWidth-1:0] data);
    rx_wvalid_i   = !to_resp;
    resp_wvalid_i = to_resp;
    rx_wdata_i    = data;
    resp_wdata_i  = data;
    while (to_resp ? !resp_wready_o : !rx_wready_o) begin
      next_cycle();
    end
    next_cycle();
    rx_wvalid_i   = 1'b0;
    resp_wvalid_i = 1'b0;
  endtask

  task automatic register_test();
    reg_rsp_t rsp;
    reg_read(RegQueueThld, rsp);
    check_rsp("queue thld after reset", acked('0), rsp);
    reg_read(RegDataThld, rsp);
    check_rsp("data thld after reset", acked('0), rsp);
    reg_read(RegResetCtrl, rsp);
    check_rsp("reset ctrl after reset", acked('0), rsp);
    reg_read(RegQueueStatus, rsp);
    check_rsp("status after reset", acked(32'hf), rsp);
    reg_write(RegQueueThld, 32'hffff_f7f5); // Only bits 11:8 and 3:0 are kept
    reg_read(RegQueueThld, rsp);
    check_rsp("queue thld readback", acked(32'h0000_0705), rsp);
    reg_write(RegDataThld, 32'h1234_0a06);
    reg_read(RegDataThld, rsp);
    check_rsp("data thld readback", acked(32'h0000_0a06), rsp);
    reg_read(AddrWidth'(7), rsp);
    check_rsp("unknown offset", reg_rsp_t'{ack: 1'b1, err: 1'b1, rdata: '0}, rsp);
  endtask

  task automatic command_test();
    logic [DataWidth-1:0] w0;
    logic [DataWidth-1:0] w1;
    reg_rsp_t             rsp;
    cmd_rready_i = 1'b0;
    // Fill the queue and leave one more command in the assembler
    for (int i = 0; i < CmdDepth + 2; i++) begin
      w0 = $urandom();
      w1 = $urandom();
      cmd_exp.push_back({w1, w0});
      if (i < CmdDepth + 1) begin
        reg_write(RegCmdPort, w0);
        reg_write(RegCmdPort, w1);
      end
    end
    reg_start(1'b1, RegCmdPort, w0);
    repeat (8) begin
      next_cycle();
      if (reg_o.ack) begin
        stop_run("COMMAND_PORT write was acked while the command queue was full");
      end
    end
    pop_cmd("command 0");
    reg_finish(rsp);
    if (rsp.err) begin
      stop_run("Stalled COMMAND_PORT write was answered with an error");
    end
    reg_write(RegCmdPort, w1);
    for (int i = 1; i < CmdDepth + 2; i++) begin
      pop_cmd($sformatf("command %0d", i));
    end
    if (cmd_rvalid_o) begin
      stop_run("Command queue still offers data after all commands were read");
    end
  endtask

  task automatic tx_test();
    logic [DataWidth-1:0] w;
    reg_rsp_t             rsp;
    tx_rready_i = 1'b0;
    for (int i = 0; i <= TxDepth; i++) begin
      w = $urandom();
      word_exp.push_back(w);
      if (i < TxDepth) begin
        reg_write(RegXferPort, w);
      end
    end
    reg_start(1'b1, RegXferPort, w); // One word too many
    repeat (8) begin
      next_cycle();
      if (reg_o.ack) begin
        stop_run("XFER_DATA_PORT write was acked while the TX queue was full");
      end
    end
    pop_tx("tx word 0");
    reg_finish(rsp);
    if (rsp.err) begin
      stop_run("Stalled XFER_DATA_PORT write was answered with an error");
    end
    for (int i = 1; i <= TxDepth; i++) begin
      pop_tx($sformatf("tx word %0d", i));
    end
  endtask

  task automatic rx_resp_test();
    logic [DataWidth-1:0] rx_words [4];
    logic [DataWidth-1:0] resp_words [4];
    reg_rsp_t             rsp;
    for (int i = 0; i < 4; i++) begin
      rx_words[i]   = $urandom();
      resp_words[i] = $urandom();
      push_word(1'b0, rx_words[i]);
      push_word(1'b1, resp_words[i]);
    end
    for (int i = 0; i < 4; i++) begin
      reg_read(RegXferPort, rsp);
      check_rsp($sformatf("rx word %0d", i), acked(rx_words[i]), rsp);
    end
    for (int i = 0; i < 4; i++) begin
      reg_read(RegRespPort, rsp);
      check_rsp($sformatf("response %0d", i), acked(resp_words[i]), rsp);
    end
  endtask

  task automatic thld_test();
    thld_t                raw;
    logic [DataWidth-1:0] r;
    // Every field value once, then a few random mixes
    for (int i = 0; i < 20; i++) begin
      r   = $urandom();
      raw = (i < 16) ? {4{ThldWidth'(i)}} : r[15:0];
      reg_write(RegQueueThld, {20'h0, raw.resp, 4'h0, raw.cmd});
      reg_write(RegDataThld, {20'h0, raw.tx, 4'h0, raw.rx});
      next_cycle();
      check_thld($sformatf("thresholds %0d", i), clamp_thld(raw), thld_o);
    end
  endtask

  task automatic queue_reset_test();
    reg_rsp_t rsp;
    tx_rready_i = 1'b0;
    for (int i = 0; i < 3; i++) begin
      reg_write(RegXferPort, $urandom());
    end
    reg_read(RegQueueStatus, rsp);
    check_rsp("status with tx data", acked(32'hb), rsp);
    reg_write(RegResetCtrl, 32'h4);
    do begin
      reg_read(RegResetCtrl, rsp); // Clears by itself once the queue is empty
    end while (rsp.rdata[2]);
    check_rsp("reset ctrl after tx reset", acked('0), rsp);
    reg_read(RegQueueStatus, rsp);
    check_rsp("status after tx reset", acked(32'hf), rsp);
    if (tx_rvalid_o) begin
      stop_run("TX queue still offers data after its reset");
    end
  endtask

  initial begin
    void'($urandom(Seed));
    rst_ni        = 1'b0;
    reg_req_i     = 1'b0;
    reg_i         = '0;
    cmd_rready_i  = 1'b0;
    tx_rready_i   = 1'b0;
    rx_wvalid_i   = 1'b0;
    rx_wdata_i    = '0;
    resp_wvalid_i = 1'b0;
    resp_wdata_i  = '0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    next_cycle();
    register_test();
    command_test();
    tx_test();
    rx_resp_test();
    thld_test();
    queue_reset_test();
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
verilog/hci_pkg.sv
verilog/hci_sync_fifo.sv
verilog/hci_read_buffer.sv
verilog/hci_queue_ctrl.sv
verilog/hci_cmd_assembler.sv
verilog/hci_reg_decode.sv
verilog/hci_pio_top.sv
dv/hci_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it, the exit status is the simulator's

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module hci_tb -f list.f -o hci_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/hci_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
fi
exit $status
